// File: source/params.sv
// Matrix geometry and command opcodes
package params;

    localparam int ROWS = 8;
    localparam int PIXEL_WIDTH = 8;  // Columns per row.
    localparam int BYTES_PER_PIXEL = 3;
    localparam int FB_BYTES = ROWS * PIXEL_WIDTH * BYTES_PER_PIXEL;

    localparam int FIFO_DEPTH = 8;  // Power of two.

    localparam logic [7:0] OP_WRITE_ROW = 8'h01;
    localparam logic [7:0] OP_FILL = 8'h02;

endpackage

// File: source/types.sv
// Framebuffer address types
package types;

    typedef logic [$clog2(params::ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(params::PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(params::BYTES_PER_PIXEL)-1:0] pixel_addr_t;

    // Row in the top bits, byte within pixel at the bottom.
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        pixel_addr_t pixel;
    } fb_addr_t;

endpackage

// File: source/fb_write_if.sv
// Framebuffer write port
interface fb_write_if;

    types::fb_addr_t addr;
    logic [7:0] data;
    logic write_enable;
    logic access_start;  // Toggles once per byte.

    modport writer (
        output addr,
        output data,
        output write_enable,
        output access_start
    );

    modport ram (
        input addr,
        input data,
        input write_enable,
        input access_start
    );

endinterface

// File: source/byte_fifo.sv
// Input byte FIFO
module byte_fifo (
    input logic clk,
    input logic reset,
    input logic [7:0] in_data,
    input logic in_valid,
    input logic pop,
    output logic in_ready,
    output logic [7:0] out_data,
    output logic out_valid
);
    typedef logic [$clog2(params::FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(params::FIFO_DEPTH + 1)-1:0] count_t;

    logic [7:0] mem [params::FIFO_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t count;
    logic push;

    assign push = in_valid && in_ready;
    assign in_ready = count != count_t'(params::FIFO_DEPTH);  // Back-pressure when full.
    assign out_valid = count != '0;
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps naturally.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/cmd_dispatch.sv
// Command opcode dispatcher
module cmd_dispatch (
    input logic clk,
    input logic reset,
    input logic [7:0] fifo_data,
    input logic fifo_valid,
    input logic row_done,
    input logic fill_done,
    output logic fifo_pop,
    output logic [7:0] cmd_data,
    output logic row_enable,
    output logic fill_start,
    output logic [7:0] fill_value,
    output logic busy_cmd
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROW,
        ST_FILL
    } state_t;

    // Row byte plus all pixel bytes of one row.
    typedef logic [$clog2(params::PIXEL_WIDTH * params::BYTES_PER_PIXEL + 2)-1:0] row_cnt_t;

    state_t state;
    row_cnt_t row_cnt;
    logic row_more;
    logic fill_armed;

    assign row_more = row_cnt != row_cnt_t'(params::PIXEL_WIDTH * params::BYTES_PER_PIXEL + 1);
    assign busy_cmd = state != ST_IDLE;

    always_comb begin
        case (state)
            ST_IDLE: fifo_pop = fifo_valid;
            ST_ROW: fifo_pop = fifo_valid && row_more;
            ST_FILL: fifo_pop = fifo_valid && !fill_armed;  // Stall during fill.
            default: fifo_pop = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            row_cnt <= '0;
            fill_armed <= 1'b0;
            row_enable <= 1'b0;
            fill_start <= 1'b0;
        end else begin
            row_enable <= 1'b0;
            fill_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    row_cnt <= '0;
                    fill_armed <= 1'b0;
                    if (fifo_pop) begin
                        if (fifo_data == params::OP_WRITE_ROW) begin
                            state <= ST_ROW;
                        end else if (fifo_data == params::OP_FILL) begin
                            state <= ST_FILL;
                        end
                    end
                end
                ST_ROW: begin
                    if (fifo_pop) begin
                        row_enable <= 1'b1;  // Byte follows one cycle later.
                        row_cnt <= row_cnt + 1'b1;
                    end
                    if (row_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FILL: begin
                    if (fifo_pop) begin
                        fill_armed <= 1'b1;
                        fill_start <= 1'b1;
                    end
                    if (fill_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            cmd_data <= fifo_data;
        end
        if (fifo_pop && state == ST_FILL) begin
            fill_value <= fifo_data;
        end
    end

endmodule

// File: source/cmd_read_row.sv
// Write-row command handler
module cmd_read_row (
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    fb_write_if.writer fb,
    output logic done
);
    typedef enum logic [1:0] {
        ST_CAPTURE,
        ST_PRIME,
        ST_CONTENT,
        ST_FINISH
    } state_t;

    state_t state;
    logic last_byte;

    // Current write is column 0, byte 1, so the next one is the final byte.
    assign last_byte = fb.addr.col == '0 && fb.addr.pixel == types::pixel_addr_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_CAPTURE;
            fb.addr <= '0;
            fb.write_enable <= 1'b0;
            fb.access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_CAPTURE: begin
                    if (enable) begin
                        fb.addr.row <= types::row_addr_t'(data_in);
                        state <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    if (enable) begin
                        // Rows are sent from the top column and byte.
                        fb.addr.col <= types::col_addr_t'(params::PIXEL_WIDTH - 1);
                        fb.addr.pixel <= types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
                        fb.write_enable <= 1'b1;
                        fb.access_start <= !fb.access_start;
                        state <= ST_CONTENT;
                    end
                end
                ST_CONTENT: begin
                    if (enable) begin
                        fb.access_start <= !fb.access_start;
                        if (fb.addr.pixel == '0) begin
                            fb.addr.pixel <= types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
                            fb.addr.col <= fb.addr.col - 1'b1;  // Next column down.
                        end else begin
                            fb.addr.pixel <= fb.addr.pixel - 1'b1;
                        end
                        if (last_byte) begin
                            state <= ST_FINISH;
                        end
                    end
                end
                ST_FINISH: begin
                    fb.write_enable <= 1'b0;
                    done <= 1'b1;
                    state <= ST_CAPTURE;
                end
                default: state <= ST_CAPTURE;
            endcase
        end
    end

    // Pixel bytes ride along with each strobe toggle.
    always_ff @(posedge clk) begin
        if (enable && state != ST_CAPTURE) begin
            fb.data <= data_in;
        end
    end

endmodule

// File: source/cmd_fill.sv
// Fill command handler
module cmd_fill (
    input logic clk,
    input logic reset,
    input logic start,
    input logic [7:0] value,
    fb_write_if.writer fb,
    output logic done
);
    logic active;
    logic pixel_last;
    logic col_last;
    logic row_last;

    assign pixel_last = fb.addr.pixel == types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
    assign col_last = fb.addr.col == types::col_addr_t'(params::PIXEL_WIDTH - 1);
    assign row_last = fb.addr.row == types::row_addr_t'(params::ROWS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            fb.addr <= '0;
            fb.write_enable <= 1'b0;
            fb.access_start <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                fb.addr <= '0;
                fb.write_enable <= 1'b1;
                fb.access_start <= !fb.access_start;  // First byte.
            end else if (active) begin
                if (row_last && col_last && pixel_last) begin
                    active <= 1'b0;
                    fb.write_enable <= 1'b0;
                    done <= 1'b1;
                end else begin
                    fb.access_start <= !fb.access_start;
                    if (pixel_last) begin
                        fb.addr.pixel <= '0;
                        fb.addr.col <= col_last ? '0 : fb.addr.col + 1'b1;
                        if (col_last) begin
                            fb.addr.row <= fb.addr.row + 1'b1;
                        end
                    end else begin
                        fb.addr.pixel <= fb.addr.pixel + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fb.data <= value;  // Held for the whole fill.
        end
    end

endmodule

// File: source/framebuffer_ram.sv
// Framebuffer memory
module framebuffer_ram (
    input logic clk,
    input logic reset,
    fb_write_if.ram row_port,
    fb_write_if.ram fill_port,
    input types::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);
    typedef logic [$clog2(params::FB_BYTES)-1:0] index_t;

    logic [7:0] mem [params::FB_BYTES];
    logic row_seen;
    logic fill_seen;
    logic row_req;
    logic fill_req;
    logic req_valid;
    types::fb_addr_t req_addr;
    logic [7:0] req_data;

    function automatic index_t lin_addr(input types::fb_addr_t a);
        return index_t'(a.row) * index_t'(params::PIXEL_WIDTH * params::BYTES_PER_PIXEL)
             + index_t'(a.col) * index_t'(params::BYTES_PER_PIXEL)
             + index_t'(a.pixel);
    endfunction

    assign row_req = row_port.write_enable && (row_port.access_start != row_seen);
    assign fill_req = fill_port.write_enable && (fill_port.access_start != fill_seen);

    always_ff @(posedge clk) begin
        if (reset) begin
            row_seen <= 1'b0;
            fill_seen <= 1'b0;
            req_valid <= 1'b0;
            for (int i = 0; i < params::FB_BYTES; i++) begin
                mem[i] <= '0;  // Blank display.
            end
        end else begin
            row_seen <= row_port.access_start;
            fill_seen <= fill_port.access_start;
            req_valid <= row_req || fill_req;
            if (req_valid) begin
                mem[lin_addr(req_addr)] <= req_data;
            end
        end
    end

    // Handlers never overlap, row port wins anyway.
    always_ff @(posedge clk) begin
        if (row_req) begin
            req_addr <= row_port.addr;
            req_data <= row_port.data;
        end else if (fill_req) begin
            req_addr <= fill_port.addr;
            req_data <= fill_port.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[lin_addr(rd_addr)];
    end

endmodule

// File: source/led_frame_ctrl.sv
// LED matrix framebuffer
// Command front end
module led_frame_ctrl (
    input logic clk,
    input logic reset,
    input logic [7:0] in_data,
    input logic in_valid,
    output logic in_ready,
    input types::fb_addr_t rd_addr,
    output logic [7:0] rd_data,
    output logic busy
);
    logic [7:0] fifo_data;
    logic fifo_valid;
    logic fifo_pop;
    logic [7:0] cmd_data;
    logic row_enable;
    logic row_done;
    logic fill_start;
    logic [7:0] fill_value;
    logic fill_done;
    logic busy_cmd;

    fb_write_if row_fb ();
    fb_write_if fill_fb ();

    assign busy = busy_cmd || fifo_valid;  // Pending bytes count as busy.

    byte_fifo byte_fifo_inst (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .pop(fifo_pop),
        .in_ready(in_ready),
        .out_data(fifo_data),
        .out_valid(fifo_valid)
    );

    cmd_dispatch cmd_dispatch_inst (
        .clk(clk),
        .reset(reset),
        .fifo_data(fifo_data),
        .fifo_valid(fifo_valid),
        .row_done(row_done),
        .fill_done(fill_done),
        .fifo_pop(fifo_pop),
        .cmd_data(cmd_data),
        .row_enable(row_enable),
        .fill_start(fill_start),
        .fill_value(fill_value),
        .busy_cmd(busy_cmd)
    );

    cmd_read_row cmd_read_row_inst (
        .clk(clk),
        .reset(reset),
        .data_in(cmd_data),
        .enable(row_enable),
        .fb(row_fb.writer),
        .done(row_done)
    );

    cmd_fill cmd_fill_inst (
        .clk(clk),
        .reset(reset),
        .start(fill_start),
        .value(fill_value),
        .fb(fill_fb.writer),
        .done(fill_done)
    );

    framebuffer_ram framebuffer_ram_inst (
        .clk(clk),
        .reset(reset),
        .row_port(row_fb.ram),
        .fill_port(fill_fb.ram),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

// File: verif/led_frame_ctrl_chk.sv
// Handshake and write port assertions
module led_frame_ctrl_chk (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_ready,
    input logic fifo_valid,
    input logic fifo_pop,
    input logic row_strobe,
    input logic fill_strobe,
    input logic busy
);
    int assert_failures = 0;
    int occupancy;  // Bytes held, counted from the handshakes.

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(in_valid && in_ready) - int'(fifo_pop);
        end
    end

    // Only a full FIFO refuses a push.
    assert property (@(posedge clk) disable iff (reset)
        in_ready == (occupancy != params::FIFO_DEPTH))
    else begin
        assert_failures++;
        $error("in_ready does not follow the FIFO fill level");
    end

    assert property (@(posedge clk) disable iff (reset)
        fifo_pop |-> fifo_valid && occupancy != 0)
    else begin
        assert_failures++;
        $error("fifo_pop without a byte in the FIFO");
    end

    assert property (@(posedge clk) disable iff (reset)
        !((row_strobe != $past(row_strobe)) && (fill_strobe != $past(fill_strobe))))
    else begin
        assert_failures++;
        $error("both write ports toggled in one cycle");
    end

    assert property (@(posedge clk) reset |=> !busy)
    else begin
        assert_failures++;
        $error("busy high after reset");
    end

endmodule

bind led_frame_ctrl led_frame_ctrl_chk chk_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .fifo_valid(fifo_valid),
    .fifo_pop(fifo_pop),
    .row_strobe(row_fb.access_start),
    .fill_strobe(fill_fb.access_start),
    .busy(busy)
);

// File: verif/led_frame_ctrl_tb.sv
// LED framebuffer testbench
module led_frame_ctrl_tb;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_DIRECTED = 10;
    localparam int CYCLES_PER_CMD = 300;
    localparam int CLK_PERIOD = 4;
    localparam int WATCHDOG_TIME = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_CMD * CLK_PERIOD;
    localparam int ROW_BYTES = params::PIXEL_WIDTH * params::BYTES_PER_PIXEL;

    logic clk;
    logic reset;
    logic [7:0] in_data;
    logic in_valid;
    logic in_ready;
    types::fb_addr_t rd_addr;
    logic [7:0] rd_data;
    logic busy;

    logic [7:0] model [params::FB_BYTES];  // Expected framebuffer.
    int gap_percent;
    bit backpressure_seen;

    led_frame_ctrl led_frame_ctrl_inst (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the command sequence did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        int gap;
        gap = 0;
        if (int'($urandom_range(99)) < gap_percent) begin
            gap = int'($urandom_range(4, 1));
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        in_data = value;
        in_valid = 1'b1;
        while (!in_ready) begin  // FIFO full.
            backpressure_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic write_row(input int row);
        logic [7:0] value;
        int col;
        int pixel;
        send_byte(params::OP_WRITE_ROW);
        send_byte(8'(row));
        for (int k = 0; k < ROW_BYTES; k++) begin
            value = 8'($urandom);
            // First byte lands on the top column and byte.
            col = params::PIXEL_WIDTH - 1 - k / params::BYTES_PER_PIXEL;
            pixel = params::BYTES_PER_PIXEL - 1 - k % params::BYTES_PER_PIXEL;
            send_byte(value);
            model[row * ROW_BYTES + col * params::BYTES_PER_PIXEL + pixel] = value;
        end
    endtask

    task automatic fill_frame(input logic [7:0] value);
        send_byte(params::OP_FILL);
        send_byte(value);
        for (int i = 0; i < params::FB_BYTES; i++) begin
            model[i] = value;
        end
    endtask

    task automatic send_bad_opcode();
        logic [7:0] op;
        op = 8'($urandom);
        while (op == params::OP_WRITE_ROW || op == params::OP_FILL) begin
            op = 8'($urandom);
        end
        send_byte(op);
    endtask

    task automatic random_command();
        int kind;
        kind = int'($urandom_range(9));
        if (kind < 5) begin
            write_row(int'($urandom_range(params::ROWS - 1)));
        end else if (kind < 8) begin
            fill_frame(8'($urandom));
        end else begin
            send_bad_opcode();
        end
    endtask

    task automatic wait_idle();
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_frame();
        for (int i = 0; i < params::FB_BYTES; i++) begin
            rd_addr.row = types::row_addr_t'(i / ROW_BYTES);
            rd_addr.col = types::col_addr_t'((i % ROW_BYTES) / params::BYTES_PER_PIXEL);
            rd_addr.pixel = types::pixel_addr_t'(i % params::BYTES_PER_PIXEL);
            @(posedge clk);
            #1;  // One cycle read latency.
            check_value($sformatf("rd_data[%0d]", i), 32'(rd_data), 32'(model[i]));
        end
    endtask

    initial begin
        void'($urandom(51));
        reset = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        rd_addr = '0;
        gap_percent = 0;
        backpressure_seen = 1'b0;
        for (int i = 0; i < params::FB_BYTES; i++) begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("busy", 32'(busy), 32'(0));
        check_frame();

        gap_percent = 30;
        write_row(3);
        write_row(5);
        wait_idle();
        check_frame();

        fill_frame(8'($urandom));
        wait_idle();
        check_frame();

        send_bad_opcode();
        write_row(int'($urandom_range(params::ROWS - 1)));
        wait_idle();
        check_frame();

        // Back to back while the fill stalls the dispatcher.
        gap_percent = 0;
        backpressure_seen = 1'b0;
        fill_frame(8'($urandom));
        write_row(0);
        write_row(7);
        fill_frame(8'($urandom));
        write_row(2);
        wait_idle();
        check_value("in_ready_low_seen", 32'(backpressure_seen), 32'(1));
        check_frame();

        gap_percent = 30;
        repeat (NUM_RANDOM) random_command();
        wait_idle();
        check_frame();

        if (led_frame_ctrl_inst.chk_inst.assert_failures == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Bound assertions failed during the run");
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: led_frame_ctrl.f
source/params.sv
source/types.sv
source/fb_write_if.sv
source/byte_fifo.sv
source/cmd_dispatch.sv
source/cmd_read_row.sv
source/cmd_fill.sv
source/framebuffer_ram.sv
source/led_frame_ctrl.sv
verif/led_frame_ctrl_chk.sv
verif/led_frame_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= led_frame_ctrl_tb
FILELIST ?= led_frame_ctrl.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "FAIL: pass message not found in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
